/* compile.f */
rtl/mipsPkg.sv
rtl/regFile.sv
rtl/alu.sv
rtl/controlUnit.sv
rtl/datapath.sv
rtl/mipsCore.sv
sim/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module mipsCoreTb \
  && { OUT=$(./obj_dir/VmipsCoreTb); echo "$OUT"; } \
  && echo "$OUT" | grep -q "SIMULATION PASSED" \
  || { echo "run did not pass"; exit 1; }
exit 0

/* sim/mipsCoreTb.sv */
`default_nettype none

module mipsCoreTb;

  localparam int driveDelay = 10;   // after the rising edge
  localparam int cycleLimit = 2000; // per program
  localparam int programs   = 3;    // per test

  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] data;
    logic [31:0] cycle; // counted from reset release
  } storeT;

  logic            clk;
  logic            reset;
  logic [31:0]     readData;
  mipsPkg::memReqT memReq;
  logic [31:0]     mem [128];      // words 0-63 program, 64-127 data
  logic [31:0]     modelMem [128];
  logic [31:0]     prog [64];
  logic [15:0]     lfsr = 16'd54717;
  storeT           expected [$];
  string           testName;
  int              testErrors;
  int              totalErrors;
  int              testsRun;
  int              testsFailed;

  mipsCore u_dut (
    .clk      (clk),
    .reset    (reset),
    .readData (readData),
    .memReq   (memReq)
  );

  always #50 clk = ~clk;

  assign readData = mem[memReq.adr[8:2]]; // combinational read port

  // one LFSR step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [4:0] randReg(); // working set $0-$7
    return 5'(randBits(3));
  endfunction

  function automatic logic [31:0] fillWord(input int i);
    return 32'h5A3C_0000 ^ (32'(i) * 32'h0001_0405);
  endfunction

  function automatic logic [31:0] rInstr(input logic [5:0] fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd);
    return {6'b0, rs, rt, rd, 5'b0, fn};
  endfunction

  function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jInstr(input logic [25:0] target); // word index
    return {mipsPkg::opJ, target};
  endfunction

  function automatic logic [31:0] randomAlu();
    logic [31:0] w;
    case (3'(randBits(3)))
      3'd0: w = rInstr(mipsPkg::fnAdd, randReg(), randReg(), randReg());
      3'd1: w = rInstr(mipsPkg::fnSub, randReg(), randReg(), randReg());
      3'd2: w = rInstr(mipsPkg::fnAnd, randReg(), randReg(), randReg());
      3'd3: w = rInstr(mipsPkg::fnOr, randReg(), randReg(), randReg());
      3'd4: w = rInstr(mipsPkg::fnSlt, randReg(), randReg(), randReg());
      3'd5, 3'd6: w = iInstr(mipsPkg::opAddi, randReg(), randReg(), 16'(randBits(16)));
      default: w = iInstr(mipsPkg::opOri, randReg(), randReg(), 16'(randBits(16)));
    endcase
    return w;
  endfunction

  // base $0, one of data words 64-71
  function automatic logic [31:0] memInstr(input logic [5:0] op);
    return iInstr(op, 5'd0, randReg(), 16'(256 + 4 * randBits(3)));
  endfunction

  task automatic buildProgram(input int kind);
    int         off;
    logic [4:0] rs;
    for (int r = 1; r < 8; r++) begin
      prog[r-1] = iInstr(randBits(1) ? mipsPkg::opAddi : mipsPkg::opOri, 5'd0, 5'(r),
                         16'(randBits(16)));
    end
    for (int i = 7; i < 55; i++) begin // random body
      off = int'(randBits(2)); // forward skip
      if (i + 1 + off > 55) begin
        off = 54 - i;
      end
      rs = randReg();
      if (kind == 0) begin
        prog[i] = randomAlu();
      end else if (kind == 1) begin
        case (2'(randBits(2)))
          2'd0: prog[i] = randomAlu();
          2'd2: prog[i] = memInstr(mipsPkg::opLw);
          default: prog[i] = memInstr(mipsPkg::opSw);
        endcase
      end else begin
        case (3'(randBits(3)))
          3'd0: prog[i] = iInstr(mipsPkg::opBeq, rs, randBits(1) ? rs : randReg(), 16'(off));
          3'd1: prog[i] = iInstr(mipsPkg::opBne, rs, randBits(1) ? rs : randReg(), 16'(off));
          3'd2: prog[i] = jInstr(26'(i + 1 + off));
          3'd3: prog[i] = memInstr(mipsPkg::opSw);
          default: prog[i] = randomAlu();
        endcase
      end
    end
    for (int r = 0; r < 8; r++) begin
      prog[55+r] = iInstr(mipsPkg::opSw, 5'd0, 5'(r), 16'(384 + 4 * r)); // dump to 96-103
    end
    prog[63] = jInstr(26'd63); // spin
  endtask

  // ISA reference model that times each store by the per-instruction cycle table
  task automatic runModel();
    logic [31:0] r [32];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] adr;
    int          cycle;
    storeT       st;
    bit          done;
    for (int i = 0; i < 32; i++) begin
      r[i] = '0;
    end
    pc    = '0;
    cycle = 0;
    done  = 1'b0;
    expected.delete();
    for (int step = 0; step < 500 && !done; step++) begin
      ins = modelMem[pc[8:2]];
      a   = r[ins[25:21]];
      b   = r[ins[20:16]];
      imm = {{16{ins[15]}}, ins[15:0]};
      adr = a + imm;
      if (ins[31:26] == mipsPkg::opJ && ins[25:0] == 26'(pc[31:2])) begin
        done = 1'b1; // self jump ends the program
      end else begin
        pc = pc + 32'd4;
        case (ins[31:26])
          mipsPkg::opRType: begin
            case (ins[5:0])
              mipsPkg::fnSub: r[ins[15:11]] = a - b;
              mipsPkg::fnAnd: r[ins[15:11]] = a & b;
              mipsPkg::fnOr:  r[ins[15:11]] = a | b;
              mipsPkg::fnSlt: r[ins[15:11]] = {31'b0, $signed(a) < $signed(b)};
              default:        r[ins[15:11]] = a + b;
            endcase
            cycle += 4;
          end
          mipsPkg::opLw: begin
            r[ins[20:16]] = modelMem[adr[8:2]];
            cycle += 5;
          end
          mipsPkg::opSw: begin
            st.adr   = adr;
            st.data  = b;
            st.cycle = 32'(cycle + 3); // memWr is the fourth cycle
            expected.push_back(st);
            modelMem[adr[8:2]] = b;
            cycle += 4;
          end
          mipsPkg::opBeq, mipsPkg::opBne: begin
            if ((a == b) == (ins[31:26] == mipsPkg::opBeq)) begin
              pc = pc + (imm << 2);
            end
            cycle += 3;
          end
          mipsPkg::opAddi: begin
            r[ins[20:16]] = a + imm;
            cycle += 4;
          end
          mipsPkg::opOri: begin
            r[ins[20:16]] = a | {16'b0, ins[15:0]};
            cycle += 4;
          end
          mipsPkg::opJ: begin
            pc = {pc[31:28], ins[25:0], 2'b00};
            cycle += 3;
          end
          default: cycle += 2;
        endcase
        r[0] = '0;
      end
    end
    assert (done) else begin
      $display("%s: model never reached the final self jump", testName);
      testErrors++;
    end
  endtask

  task automatic stepCycle();
    @(posedge clk);
    #driveDelay;
  endtask

  task automatic checkWord(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR %s %s: expected %h, actual %h", testName, what, exp, act);
      testErrors++;
    end
  endtask

  task automatic applyReset();
    reset = 1'b1;
    for (int i = 0; i < 10; i++) begin
      stepCycle();
      checkWord("reset adr", 32'd0, memReq.adr);
      checkWord("reset memWrite", 32'd0, 32'(memReq.memWrite));
    end
    reset = 1'b0;
    checkWord("first cycle adr", 32'd0, memReq.adr); // still fetching word 0
  endtask

  task automatic runProgram(input int kind);
    int    cycle;
    int    idx;
    int    tail;
    storeT exp;
    reset = 1'b1; // hold the core while memory reloads
    buildProgram(kind);
    for (int i = 0; i < 128; i++) begin
      mem[i]      = (i < 64) ? prog[i] : fillWord(i);
      modelMem[i] = mem[i];
    end
    runModel();
    applyReset();
    cycle = 0;
    idx   = 0;
    tail  = 0;
    while (tail < 8 && cycle < cycleLimit) begin
      if (memReq.memWrite) begin
        assert (idx < expected.size()) else begin
          $display("%s: store to %h after the last store of the model", testName, memReq.adr);
          testErrors++;
        end
        if (idx < expected.size()) begin
          exp = expected[idx];
          checkWord("store adr", exp.adr, memReq.adr);
          checkWord("store data", exp.data, memReq.writeData);
          checkWord("store cycle", exp.cycle, 32'(cycle));
        end
        mem[memReq.adr[8:2]] = memReq.writeData;
        idx++;
      end
      if (idx >= expected.size()) begin
        tail++; // watch a few cycles past the last store
      end
      stepCycle();
      cycle++;
    end
    assert (tail >= 8) else begin
      $display("%s: timed out after %0d cycles with %0d of %0d stores seen", testName, cycle,
               idx, expected.size());
      testErrors++;
    end
  endtask

  task automatic runTest(input string name, input int kind);
    testName   = name;
    testErrors = 0;
    if (kind < 0) begin
      applyReset();
    end else begin
      for (int p = 0; p < programs; p++) begin
        runProgram(kind);
      end
    end
    testsRun++;
    totalErrors += testErrors;
    if (testErrors != 0) begin
      testsFailed++;
    end
    $display("test %s: %s, %0d errors", name, (testErrors == 0) ? "ok" : "bad", testErrors);
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    testsRun    = 0;
    testsFailed = 0;
    totalErrors = 0;
    for (int i = 0; i < 128; i++) begin
      mem[i] = fillWord(i);
    end
    runTest("reset", -1);
    runTest("aluOps", 0);
    runTest("memAccess", 1);
    runTest("controlFlow", 2);
    $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors);
    if (totalErrors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/mipsCore.sv */
`default_nettype none

module mipsCore (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [mipsPkg::dataWidth-1:0] readData, // combinational read of memReq.adr
  output mipsPkg::memReqT               memReq
);

  mipsPkg::ctrlWordT ctrl;
  mipsPkg::dpStatusT status;

  controlUnit u_controlUnit (
    .clk    (clk),
    .reset  (reset),
    .status (status),
    .ctrl   (ctrl)
  );

  datapath u_datapath (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .readData (readData),
    .status   (status),
    .memReq   (memReq)
  );

endmodule

`default_nettype wire

/* rtl/datapath.sv */
`default_nettype none

module datapath (
  input  logic                          clk,
  input  logic                          reset,
  input  mipsPkg::ctrlWordT             ctrl,
  input  logic [mipsPkg::dataWidth-1:0] readData,
  output mipsPkg::dpStatusT             status,
  output mipsPkg::memReqT               memReq
);

  logic [mipsPkg::dataWidth-1:0]    pc;
  logic [mipsPkg::dataWidth-1:0]    instr;
  logic [mipsPkg::dataWidth-1:0]    data;   // memory read, one cycle later
  logic [mipsPkg::dataWidth-1:0]    tempA;  // rs value
  logic [mipsPkg::dataWidth-1:0]    tempB;  // rt value, also store data
  logic [mipsPkg::dataWidth-1:0]    aluOut;
  logic [mipsPkg::dataWidth-1:0]    pcNext;
  logic [mipsPkg::dataWidth-1:0]    readA;
  logic [mipsPkg::dataWidth-1:0]    readB;
  logic [mipsPkg::dataWidth-1:0]    writeValue;
  logic [mipsPkg::dataWidth-1:0]    srcA;
  logic [mipsPkg::dataWidth-1:0]    srcB;
  logic [mipsPkg::dataWidth-1:0]    aluResult;
  logic [mipsPkg::dataWidth-1:0]    signImm;
  logic [mipsPkg::dataWidth-1:0]    immExt; // per-opcode extension
  logic [mipsPkg::dataWidth-1:0]    jumpAddr;
  logic [mipsPkg::regAddrWidth-1:0] writeAddr;
  logic                             zero;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc     <= '0;
      instr  <= '0;
      data   <= '0;
      tempA  <= '0;
      tempB  <= '0;
      aluOut <= '0;
    end else begin
      data   <= readData;
      tempA  <= readA;
      tempB  <= readB;
      aluOut <= aluResult;
      if (ctrl.irWrite) begin
        instr <= readData;
      end
      if (ctrl.pcEn) begin
        pc <= pcNext;
      end
    end
  end

  assign status.op    = mipsPkg::opcodeT'(instr[31:26]);
  assign status.funct = mipsPkg::functT'(instr[5:0]);
  assign status.zero  = zero;

  assign signImm  = {{16{instr[15]}}, instr[15:0]};
  assign immExt   = (status.op == mipsPkg::opOri) ? {16'b0, instr[15:0]} : signImm;
  assign jumpAddr = {pc[31:28], instr[25:0], 2'b00}; // pc already advanced

  assign writeAddr  = ctrl.regDst ? instr[15:11] : instr[20:16]; // rd : rt
  assign writeValue = ctrl.memToReg ? data : aluOut;
  assign srcA       = ctrl.aluSrcA ? tempA : pc;

  always_comb begin
    case (ctrl.aluSrcB)
      mipsPkg::fromRegB:  srcB = tempB;
      mipsPkg::constFour: srcB = 32'd4;
      mipsPkg::extImm:    srcB = immExt;
      default:            srcB = {signImm[29:0], 2'b00}; // word offset
    endcase
  end

  always_comb begin
    case (ctrl.pcSrc)
      mipsPkg::fromAluOut: pcNext = aluOut;   // branch target
      mipsPkg::jumpTarget: pcNext = jumpAddr;
      default:             pcNext = aluResult; // pc + 4
    endcase
  end

  regFile u_regFile (
    .clk        (clk),
    .regWrite   (ctrl.regWrite),
    .readAddrA  (instr[25:21]),
    .readAddrB  (instr[20:16]),
    .writeAddr  (writeAddr),
    .writeValue (writeValue),
    .readA      (readA),
    .readB      (readB)
  );

  alu u_alu (
    .a       (srcA),
    .b       (srcB),
    .aluCtrl (ctrl.aluCtrl),
    .result  (aluResult),
    .zero    (zero)
  );

  // single port shared by fetch and data access
  assign memReq.adr       = ctrl.iOrD ? aluOut : pc;
  assign memReq.writeData = tempB;
  assign memReq.memWrite  = ctrl.memWrite;

  // store address comes from the sequencer's memAdr step
  assert property (@(posedge clk) disable iff (reset)
    memReq.memWrite |-> memReq.adr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* rtl/controlUnit.sv */
`default_nettype none

module controlUnit (
  input  logic               clk,
  input  logic               reset,
  input  mipsPkg::dpStatusT  status,
  output mipsPkg::ctrlWordT  ctrl
);

  mipsPkg::fsmStateT state;
  mipsPkg::fsmStateT nextState;
  mipsPkg::aluOpT    aluOp;
  logic              pcWrite; // unconditional pc update
  logic              branch;  // conditional pc update
  logic              branchMet;

  // R-type ops come from funct, everything else from the sequencer
  function automatic mipsPkg::aluCtrlT aluDecode(input mipsPkg::aluOpT op,
                                                 input mipsPkg::functT fn);
    mipsPkg::aluCtrlT res;
    case (op)
      mipsPkg::aluAdd: res = mipsPkg::opAdd;
      mipsPkg::aluSub: res = mipsPkg::opSub; // branch compare
      mipsPkg::aluOr:  res = mipsPkg::opOr;  // ori
      default: begin
        case (fn)
          mipsPkg::fnAdd: res = mipsPkg::opAdd;
          mipsPkg::fnSub: res = mipsPkg::opSub;
          mipsPkg::fnAnd: res = mipsPkg::opAnd;
          mipsPkg::fnOr:  res = mipsPkg::opOr;
          mipsPkg::fnSlt: res = mipsPkg::opSlt;
          default:        res = mipsPkg::opAdd; // unknown funct
        endcase
      end
    endcase
    return res;
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= mipsPkg::fetch;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    case (state)
      mipsPkg::fetch: nextState = mipsPkg::decode;
      mipsPkg::decode: begin
        case (status.op)
          mipsPkg::opLw, mipsPkg::opSw: nextState = mipsPkg::memAdr;
          mipsPkg::opRType: nextState = mipsPkg::rTypeEx;
          mipsPkg::opBeq:   nextState = mipsPkg::beqEx;
          mipsPkg::opBne:   nextState = mipsPkg::bneEx;
          mipsPkg::opAddi:  nextState = mipsPkg::addiEx;
          mipsPkg::opOri:   nextState = mipsPkg::oriEx;
          mipsPkg::opJ:     nextState = mipsPkg::jEx;
          default:          nextState = mipsPkg::fetch; // treat as no-op
        endcase
      end
      mipsPkg::memAdr: begin
        if (status.op == mipsPkg::opLw) begin
          nextState = mipsPkg::memRd;
        end else begin
          nextState = mipsPkg::memWr;
        end
      end
      mipsPkg::memRd:   nextState = mipsPkg::memWb;
      mipsPkg::rTypeEx: nextState = mipsPkg::rTypeWb;
      mipsPkg::addiEx:  nextState = mipsPkg::immWb;
      mipsPkg::oriEx:   nextState = mipsPkg::immWb;
      default:          nextState = mipsPkg::fetch; // last state of every instr
    endcase
  end

  always_comb begin
    ctrl    = '0;
    pcWrite = 1'b0;
    branch  = 1'b0;
    aluOp   = mipsPkg::aluAdd;
    case (state)
      mipsPkg::fetch: begin
        ctrl.irWrite = 1'b1;
        ctrl.aluSrcB = mipsPkg::constFour; // pc + 4
        pcWrite      = 1'b1;
      end
      mipsPkg::decode: begin
        ctrl.aluSrcB = mipsPkg::branchOffset; // precompute branch target
      end
      mipsPkg::memAdr, mipsPkg::addiEx: begin
        ctrl.aluSrcA = 1'b1;
        ctrl.aluSrcB = mipsPkg::extImm;
      end
      mipsPkg::memRd: ctrl.iOrD = 1'b1;
      mipsPkg::memWb: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
      end
      mipsPkg::memWr: begin
        ctrl.iOrD     = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      mipsPkg::rTypeEx: begin
        ctrl.aluSrcA = 1'b1;
        aluOp        = mipsPkg::aluFunct;
      end
      mipsPkg::rTypeWb: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = 1'b1;
      end
      mipsPkg::beqEx, mipsPkg::bneEx: begin
        ctrl.aluSrcA = 1'b1;
        ctrl.pcSrc   = mipsPkg::fromAluOut; // target from decode
        aluOp        = mipsPkg::aluSub;
        branch       = 1'b1;
      end
      mipsPkg::oriEx: begin
        ctrl.aluSrcA = 1'b1;
        ctrl.aluSrcB = mipsPkg::extImm;
        aluOp        = mipsPkg::aluOr;
      end
      mipsPkg::immWb: ctrl.regWrite = 1'b1;
      mipsPkg::jEx: begin
        ctrl.pcSrc = mipsPkg::jumpTarget;
        pcWrite    = 1'b1;
      end
      default: ;
    endcase
    ctrl.aluCtrl = aluDecode(aluOp, status.funct);
    ctrl.pcEn    = pcWrite | (branch & branchMet);
  end

  // bne reuses the beq compare with zero inverted
  assign branchMet = status.zero ^ (state == mipsPkg::bneEx);

  assert property (@(posedge clk) disable iff (reset)
    !$isunknown(state) && state inside {[mipsPkg::fetch:mipsPkg::bneEx]});

  // a store pulse only ever follows the address state
  assert property (@(posedge clk) disable iff (reset)
    ctrl.memWrite |-> state == mipsPkg::memWr && $past(state) == mipsPkg::memAdr);

endmodule

`default_nettype wire

/* rtl/alu.sv */
`default_nettype none

module alu (
  input  logic [mipsPkg::dataWidth-1:0] a,
  input  logic [mipsPkg::dataWidth-1:0] b,
  input  mipsPkg::aluCtrlT              aluCtrl,
  output logic [mipsPkg::dataWidth-1:0] result,
  output logic                          zero
);

  logic [mipsPkg::dataWidth-1:0] bMux;  // b or ~b
  logic [mipsPkg::dataWidth-1:0] sum;
  logic                          subtract;
  logic                          overflow;
  logic                          less;

  assign subtract = aluCtrl[2]; // set for sub and slt
  assign bMux     = subtract ? ~b : b;
  assign sum      = a + bMux + {{(mipsPkg::dataWidth-1){1'b0}}, subtract}; // carry-in

  // operands of equal sign giving a result of the other sign
  assign overflow = (a[mipsPkg::dataWidth-1] == bMux[mipsPkg::dataWidth-1]) &&
                    (sum[mipsPkg::dataWidth-1] != a[mipsPkg::dataWidth-1]);
  assign less     = sum[mipsPkg::dataWidth-1] ^ overflow; // signed a < b

  always_comb begin
    case (aluCtrl)
      mipsPkg::opAnd: result = a & b;
      mipsPkg::opOr:  result = a | b;
      mipsPkg::opSlt: result = {{(mipsPkg::dataWidth-1){1'b0}}, less};
      default:        result = sum; // add and sub
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

/* rtl/regFile.sv */
`default_nettype none

module regFile (
  input  logic                               clk,
  input  logic                               regWrite,
  input  logic [mipsPkg::regAddrWidth-1:0]   readAddrA,
  input  logic [mipsPkg::regAddrWidth-1:0]   readAddrB,
  input  logic [mipsPkg::regAddrWidth-1:0]   writeAddr,
  input  logic [mipsPkg::dataWidth-1:0]      writeValue,
  output logic [mipsPkg::dataWidth-1:0]      readA,
  output logic [mipsPkg::dataWidth-1:0]      readB
);

  logic [mipsPkg::dataWidth-1:0] regs [2**mipsPkg::regAddrWidth]; // no reset

  always_ff @(posedge clk) begin
    if (regWrite) begin
      regs[writeAddr] <= writeValue; // $0 may be written, never read back
    end
  end

  // $0 reads as zero
  assign readA = (readAddrA != '0) ? regs[readAddrA] : '0;
  assign readB = (readAddrB != '0) ? regs[readAddrB] : '0;

endmodule

`default_nettype wire

/* rtl/mipsPkg.sv */
`default_nettype none

package mipsPkg;

  localparam int dataWidth    = 32; // machine word
  localparam int regAddrWidth = 5;  // 32 registers

  typedef enum logic [5:0] {
    opRType = 6'b000000, // funct selects the operation
    opJ     = 6'b000010,
    opBeq   = 6'b000100,
    opBne   = 6'b000101,
    opAddi  = 6'b001000,
    opOri   = 6'b001101, // zero-extended immediate
    opLw    = 6'b100011,
    opSw    = 6'b101011
  } opcodeT;

  typedef enum logic [5:0] {
    fnAdd = 6'b100000,
    fnSub = 6'b100010,
    fnAnd = 6'b100100,
    fnOr  = 6'b100101,
    fnSlt = 6'b101010
  } functT;

  // codes not in sequence order
  typedef enum logic [3:0] {
    fetch   = 4'd0,
    decode  = 4'd1,
    memAdr  = 4'd2,
    memRd   = 4'd3,
    memWb   = 4'd4,
    memWr   = 4'd5,
    rTypeEx = 4'd6,
    rTypeWb = 4'd7,
    beqEx   = 4'd8,
    bneEx   = 4'd13,
    addiEx  = 4'd9,
    oriEx   = 4'd12,
    immWb   = 4'd10, // shared by addi and ori
    jEx     = 4'd11
  } fsmStateT;

  typedef enum logic [1:0] {
    aluAdd   = 2'b00,
    aluSub   = 2'b01,
    aluFunct = 2'b10, // decode from funct
    aluOr    = 2'b11
  } aluOpT;

  typedef enum logic [2:0] {
    opAnd = 3'b000,
    opOr  = 3'b001,
    opAdd = 3'b010,
    opSub = 3'b110, // bit 2 inverts b
    opSlt = 3'b111
  } aluCtrlT;

  typedef enum logic [1:0] {
    fromRegB     = 2'b00,
    constFour    = 2'b01,
    extImm       = 2'b10,
    branchOffset = 2'b11 // immediate times four
  } srcBSelT;

  typedef enum logic [1:0] {
    fromAluResult = 2'b00,
    fromAluOut    = 2'b01,
    jumpTarget    = 2'b10
  } pcSrcT;

  typedef struct packed {
    logic    pcEn;
    logic    irWrite;
    logic    regWrite;
    logic    aluSrcA;  // 0 pc, 1 tempA
    logic    iOrD;     // 0 pc, 1 aluOut
    logic    memToReg; // 0 aluOut, 1 data
    logic    regDst;   // 0 rt, 1 rd
    srcBSelT aluSrcB;
    pcSrcT   pcSrc;
    aluCtrlT aluCtrl;
    logic    memWrite;
  } ctrlWordT;

  typedef struct packed {
    opcodeT op;
    functT  funct;
    logic   zero;
  } dpStatusT;

  typedef struct packed {
    logic [dataWidth-1:0] adr;
    logic [dataWidth-1:0] writeData;
    logic                 memWrite;
  } memReqT;

endpackage

`default_nettype wire
